//--- project.f
verilog/etrace_pkg.sv
verilog/emitter_pkg.sv
verilog/addr_field_gen.sv
verilog/branch_map_field.sv
verilog/packet_assembler.sv
verilog/trace_packet_emitter.sv
verification/trace_emitter_tb.sv

//--- verification/emitter_input.txt
# hex columns: fmt sf lc_tc_sel lc_cause tc_cause lc_int tc_int branch taken priv thaddr
# ienable mode qual_status ioptions lc_updiscon branches keep_bits iaddr tvec(31:2) epc
# lc_tval tc_tval branch_map, then expected type length payload
3 3 0 0 0 0 0 0 0 0 0 1 0 2 5 0 0 0 0 0 0 0 0 0 5 2 59f
3 2 0 0 0 0 0 0 0 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 1 3b
3 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 7 80001234 0 0 0 0 0 2 2 1a33
3 0 0 0 0 0 0 1 1 3 0 0 0 0 0 0 0 a 405678 0 0 0 0 0 2 3 2b3c63
3 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 19 deadbeef 0 0 0 0 0 2 5 6f56df7793
3 1 1 2 b 0 1 0 0 3 1 0 0 0 0 0 0 10 100 40 2000 11112222 abcd 0 3 8 2af3404035f7
3 1 0 2 b 0 1 1 1 1 0 0 0 0 0 0 0 c 2000 40 2000 11112222 abcd 0 3 8 444488888000127
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 a 2345 0 0 0 0 0 1 4 d16
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 20 80002400 0 0 0 0 0 1 6 6000002ee
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 8 2480 0 0 0 0 0 1 3 1fa02
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 80000000 0 0 0 0 0 1 2 1fe
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8 80000010 0 0 0 0 7fffffff 0 3 3f8801
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 8 80000020 0 0 0 0 7fffffff 0 3 11085
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 5 10 1000 0 0 0 0 155 0 5 fe0aa95
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 11 c 1234 0 0 0 0 3ffff 0 6 7e0234ffffc5
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 18 9 1334 0 0 0 0 abcdef 0 7 10055e6f7e1
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1f 20 5000 0 0 0 0 7fffffff 0 5 3ffffffffd
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8 5010 0 0 0 0 0 1 3 42
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 20 9999 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8 5020 0 0 0 0 0 1 3 42
3 1 1 2 1f 1 0 0 0 0 0 0 0 0 0 0 0 0 6000 40 3000 11112222 1 0 3 6 4f97

//--- verification/trace_emitter_tb.sv
// testbench for the trace packet emitter that replays the requests of the input file
// through the req/ack handshake and checks ack, flush and every packet field
`timescale 1ns/1ns
`default_nettype none

module trace_emitter_tb;

    import etrace_pkg::*;
    import emitter_pkg::*;

    localparam int unsigned CLK_PERIOD        = 40;
    localparam int unsigned RESET_CYCLES      = 4;
    localparam int unsigned CALL_COUNTER_SIZE = 2;
    // watchdog budget per request line
    localparam int unsigned LINE_CYCLES       = 10;

    logic           clk_i;
    logic           rst_ni;
    logic           req_i;
    trace_req_t     trace_req_i;
    logic           ack_o;
    packet_t        packet_o;
    logic           branch_map_flush_o;

    // requests and expected packets share one index
    trace_req_t     req_q[$];
    packet_t        exp_q[$];
    int             n_req = 0;

    trace_packet_emitter #(
        .CALL_COUNTER_SIZE (CALL_COUNTER_SIZE)
    ) trace_packet_emitter_i (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .req_i              (req_i),
        .trace_req_i        (trace_req_i),
        .ack_o              (ack_o),
        .packet_o           (packet_o),
        .branch_map_flush_o (branch_map_flush_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic compare_type(input string name, input packet_type_e exp,
                                input packet_type_e act);
        if (exp !== act) begin
            report_failure($sformatf("Error at %0t ns: %s expected %s, got %s",
                                     $time, name, exp.name(), act.name()));
        end
    endtask

    task automatic compare_length(input string name, input payload_len_t exp,
                                  input payload_len_t act);
        if (exp !== act) begin
            report_failure($sformatf("Error at %0t ns: %s expected %0d, got %0d",
                                     $time, name, exp, act));
        end
    endtask

    task automatic compare_payload(input string name, input payload_t exp, input payload_t act);
        if (exp !== act) begin
            report_failure($sformatf("Error at %0t ns: %s expected %h, got %h",
                                     $time, name, exp, act));
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            report_failure($sformatf("Error at %0t ns: %s expected %b, got %b",
                                     $time, name, exp, act));
        end
    endtask

    task automatic check_packet(input packet_t exp, input string tag);
        compare_type({"packet_o.ptype ", tag}, exp.ptype, packet_o.ptype);
        compare_length({"packet_o.length ", tag}, exp.length, packet_o.length);
        compare_payload({"packet_o.payload ", tag}, exp.payload, packet_o.payload);
    endtask

    // reads one request per line and skips lines starting with #
    task automatic load_requests();
        int             fd;
        int             n;
        string          line;
        logic [31:0]    v[24];
        logic [31:0]    exp_type;
        logic [31:0]    exp_len;
        payload_t       exp_payload;
        trace_req_t     r;
        packet_t        p;
        fd = $fopen("verification/emitter_input.txt", "r");
        if (fd == 0) begin
            report_failure("could not open the request file verification/emitter_input.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11],
                v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19], v[20], v[21], v[22],
                v[23], exp_type, exp_len, exp_payload);
            if (n != 27) begin
                report_failure($sformatf("request file line has %0d of 27 columns: %s", n, line));
            end
            r                 = '0;
            r.format          = format_e'(v[0][1:0]);
            r.subformat       = sync_subformat_e'(v[1][1:0]);
            r.lc_tc_sel       = v[2][0];
            r.lc_cause        = cause_t'(v[3]);
            r.tc_cause        = cause_t'(v[4]);
            r.lc_interrupt    = v[5][0];
            r.tc_interrupt    = v[6][0];
            r.tc_branch       = v[7][0];
            r.tc_branch_taken = v[8][0];
            r.tc_priv         = priv_t'(v[9]);
            r.thaddr          = v[10][0];
            r.tc_ienable      = v[11][0];
            r.encoder_mode    = v[12][0];
            r.qual_status     = qual_status_e'(v[13][1:0]);
            r.ioptions        = ioptions_e'(v[14][2:0]);
            r.lc_updiscon     = v[15][0];
            r.branches        = branch_count_t'(v[16]);
            r.keep_bits       = keep_bits_t'(v[17]);
            r.tc_iaddr        = v[18];
            // tvec column holds bits 31:2
            r.tc_tvec         = v[19][29:0];
            r.lc_epc          = v[20];
            r.lc_tval         = v[21];
            r.tc_tval         = v[22];
            r.branch_map      = branch_map_t'(v[23]);
            p.ptype           = packet_type_e'(exp_type[2:0]);
            p.length          = payload_len_t'(exp_len);
            p.payload         = exp_payload;
            req_q.push_back(r);
            exp_q.push_back(p);
        end
        $fclose(fd);
        if (req_q.size() == 0) begin
            report_failure("the request file holds no requests");
        end
        n_req = req_q.size();
    endtask

    // full four-phase cycle that starts and ends on a falling edge
    task automatic run_request(input int idx);
        string tag;
        tag = $sformatf("(request %0d)", idx);
        trace_req_i = req_q[idx];
        req_i       = 1'b1;
        // the next rising edge captures the request and raises ack
        @(negedge clk_i);
        compare_bit("ack_o", 1'b1, ack_o);
        compare_bit("branch_map_flush_o", 1'b1, branch_map_flush_o);
        check_packet(exp_q[idx], tag);
        // ack holds while req stays high and the flush pulse is over
        @(negedge clk_i);
        compare_bit("ack_o", 1'b1, ack_o);
        compare_bit("branch_map_flush_o", 1'b0, branch_map_flush_o);
        check_packet(exp_q[idx], tag);
        req_i       = 1'b0;
        trace_req_i = '0;
        @(negedge clk_i);
        compare_bit("ack_o", 1'b0, ack_o);
        compare_bit("branch_map_flush_o", 1'b0, branch_map_flush_o);
    endtask

    initial begin : watchdog
        wait (n_req > 0);
        #(n_req * LINE_CYCLES * CLK_PERIOD);
        report_failure("timeout: the handshake did not complete in time");
    end

    initial begin : main
        packet_t idle_packet;
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        req_i       = 1'b0;
        trace_req_i = '0;
        idle_packet = '0;
        load_requests();
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);
        // idle outputs out of reset
        compare_bit("ack_o", 1'b0, ack_o);
        compare_bit("branch_map_flush_o", 1'b0, branch_map_flush_o);
        check_packet(idle_packet, "(after reset)");
        foreach (req_q[i]) begin
            run_request(i);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/addr_field_gen.sv
// address path of the emitter: last emitted address, difference, trap address,
// byte-wise compression and the notify/updiscon/irreport/irdepth bits
`timescale 1ns/1ns
`default_nettype none

module addr_field_gen #(
    parameter int unsigned CALL_COUNTER_SIZE = 2
) (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  emitter_pkg::trace_req_t         trace_req_i,
    input  logic                            latest_update_i,
    output emitter_pkg::addr_field_t        addr_field_o,
    output logic [2**CALL_COUNTER_SIZE-1:0] irdepth_o
);

    import etrace_pkg::*;

    addr_t          latest_addr_q;
    addr_t          diff_addr;
    addr_t          trap_addr;
    addr_t          src_addr;
    addr_t          byte_mask;
    logic [2:0]     n_bytes;
    logic           notify;
    logic           updiscon;

    // last address sent in a packet, loaded on the capture edge
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            latest_addr_q <= '0;
        end else if (latest_update_i) begin
            latest_addr_q <= trace_req_i.tc_iaddr;
        end
    end

    // delta against the previous updating packet
    assign diff_addr = trace_req_i.tc_iaddr - latest_addr_q;

    // tvec when the handler address is reported, epc otherwise
    assign trap_addr = trace_req_i.thaddr ? {trace_req_i.tc_tvec, 2'b00} : trace_req_i.lc_epc;

    // address that gets compressed for this format
    always_comb begin
        src_addr = diff_addr;
        if (trace_req_i.format == F_SYNC) begin
            if (trace_req_i.subformat == SF_START) begin
                src_addr = trace_req_i.tc_iaddr;
            end else if (trace_req_i.subformat == SF_TRAP) begin
                src_addr = trap_addr;
            end
        end
    end

    // kept bytes, rounded up from the kept bits
    always_comb begin
        if (trace_req_i.keep_bits > XLEN) begin
            // out of range count keeps the whole address
            n_bytes = 3'(XLEN / 8);
        end else begin
            n_bytes = 3'((trace_req_i.keep_bits + 6'd7) >> 3);
        end
    end

    // zero every byte above the kept ones
    always_comb begin
        for (int i = 0; i < XLEN / 8; i++) begin
            byte_mask[8*i +: 8] = (i < n_bytes) ? 8'hff : 8'h00;
        end
    end

    // notify mirrors the address msb
    assign notify   = trace_req_i.tc_iaddr[XLEN-1];
    // inverted on an uninferable discontinuity
    assign updiscon = trace_req_i.lc_updiscon ? ~notify : notify;

    assign addr_field_o.addr      = src_addr & byte_mask;
    assign addr_field_o.n_bytes   = n_bytes;
    assign addr_field_o.trap_addr = trap_addr;
    assign addr_field_o.notify    = notify;
    assign addr_field_o.updiscon  = updiscon;
    assign addr_field_o.irreport  = updiscon;

    // no return stack, so depth just repeats updiscon
    assign irdepth_o = {(2**CALL_COUNTER_SIZE){updiscon}};

endmodule

`default_nettype wire

//--- verilog/branch_map_field.sv
// branch path of the emitter: picks the map length from the branch count
// and builds the count/map field used by format 1 packets
`timescale 1ns/1ns
`default_nettype none

module branch_map_field (
    input  emitter_pkg::trace_req_t     trace_req_i,
    output emitter_pkg::bmap_field_t    bmap_field_o
);

    import etrace_pkg::*;

    logic [4:0]     map_len;
    branch_map_t    map_mask;

    // E-Trace map length steps
    always_comb begin
        if (trace_req_i.branches == 0) begin
            map_len = 5'd0;
        end else if (trace_req_i.branches <= 1) begin
            map_len = 5'd1;
        end else if (trace_req_i.branches <= 9) begin
            map_len = 5'd9;
        end else if (trace_req_i.branches <= 17) begin
            map_len = 5'd17;
        end else if (trace_req_i.branches <= 25) begin
            map_len = 5'd25;
        end else begin
            map_len = 5'd31;
        end
    end

    // ones below map_len, all ones for a full map
    assign map_mask = ~(branch_map_t'('1) << map_len);

    assign bmap_field_o.bits    = {trace_req_i.branch_map & map_mask, trace_req_i.branches};
    assign bmap_field_o.map_len = map_len;
    // full map means no address follows
    assign bmap_field_o.full    = (trace_req_i.branches == branch_count_t'(BRANCH_MAP_LEN));

endmodule

`default_nettype wire

//--- verilog/emitter_pkg.sv
// emitter side types: the trace request, the emitted packet and the
// intermediate address and branch fields, plus the handshake states
`default_nettype none

package emitter_pkg;

    import etrace_pkg::*;

    // one trace request, valid while req_i is high
    typedef struct packed {
        format_e                format;
        sync_subformat_e        subformat;
        // cause, tval and interrupt of last and this cycle
        cause_t                 lc_cause;
        cause_t                 tc_cause;
        addr_t                  lc_tval;
        addr_t                  tc_tval;
        logic                   lc_interrupt;
        logic                   tc_interrupt;
        // picks tc over lc for the trap fields
        logic                   lc_tc_sel;
        logic                   tc_branch;
        logic                   tc_branch_taken;
        priv_t                  tc_priv;
        addr_t                  tc_iaddr;
        logic                   thaddr;
        // trap vector, two lsbs implied zero
        logic [XLEN-1:2]        tc_tvec;
        addr_t                  lc_epc;
        logic                   tc_ienable;
        logic                   encoder_mode;
        qual_status_e           qual_status;
        ioptions_e              ioptions;
        logic                   lc_updiscon;
        branch_count_t          branches;
        branch_map_t            branch_map;
        keep_bits_t             keep_bits;
    } trace_req_t;

    typedef struct packed {
        packet_type_e           ptype;
        payload_t               payload;
        payload_len_t           length;
    } packet_t;

    typedef struct packed {
        // zero above the kept bytes
        addr_t                  addr;
        logic [2:0]             n_bytes;
        addr_t                  trap_addr;
        logic                   notify;
        logic                   updiscon;
        logic                   irreport;
    } addr_field_t;

    typedef struct packed {
        // truncated map sits above the branch count
        logic [BRANCH_COUNT_LEN+BRANCH_MAP_LEN-1:0] bits;
        logic [4:0]             map_len;
        logic                   full;
    } bmap_field_t;

    typedef enum logic {
        IDLE,
        ACK
    } hs_state_e;

endpackage

`default_nettype wire

//--- verilog/etrace_pkg.sv
// protocol side of the trace emitter: E-Trace field widths and encodings
// imported by every block that packs or decodes packet fields
`default_nettype none

package etrace_pkg;

    // architecture width, fixed for RV32
    localparam int unsigned XLEN             = 32;
    localparam int unsigned CAUSE_LEN        = 5;
    localparam int unsigned PRIV_LEN         = 2;
    localparam int unsigned BRANCH_COUNT_LEN = 5;
    localparam int unsigned BRANCH_MAP_LEN   = 31;
    // enough room for call counter sizes 0 to 4
    localparam int unsigned PAYLOAD_LEN      = 96;
    // payload length in bytes
    localparam int unsigned P_LEN            = 4;

    typedef logic [XLEN-1:0]             addr_t;
    typedef logic [CAUSE_LEN-1:0]        cause_t;
    typedef logic [PRIV_LEN-1:0]         priv_t;
    typedef logic [BRANCH_COUNT_LEN-1:0] branch_count_t;
    typedef logic [BRANCH_MAP_LEN-1:0]   branch_map_t;
    typedef logic [PAYLOAD_LEN-1:0]      payload_t;
    typedef logic [P_LEN-1:0]            payload_len_t;
    // address bits to keep, 0 to XLEN
    typedef logic [5:0]                  keep_bits_t;

    // packet format, first two payload bits
    typedef enum logic [1:0] {
        F_OPT_EXT    = 2'd0,
        F_DIFF_DELTA = 2'd1,
        F_ADDR_ONLY  = 2'd2,
        F_SYNC       = 2'd3
    } format_e;

    // subformats of the sync format
    typedef enum logic [1:0] {
        SF_START,
        SF_TRAP,
        SF_CONTEXT,
        SF_SUPPORT
    } sync_subformat_e;

    typedef enum logic [1:0] {
        NO_CHANGE,
        ENDED_REP,
        TRACE_LOST,
        ENDED_NTR
    } qual_status_e;

    typedef enum logic [2:0] {
        IOPT_NONE,
        DELTA_ADDRESS,
        FULL_ADDRESS,
        IMPLICIT_EXCEPTION,
        SIJUMP,
        IMPLICIT_RETURN,
        BRANCH_PREDICTION,
        JUMP_TARGET_CACHE
    } ioptions_e;

    // reported kind of packet
    typedef enum logic [2:0] {
        F1,
        F2,
        F3SF0,
        F3SF1,
        F3SF2,
        F3SF3
    } packet_type_e;

endpackage

`default_nettype wire

//--- verilog/packet_assembler.sv
// packs the address and branch fields into one E-Trace payload per request
// and holds it under a four-phase req/ack handshake
`timescale 1ns/1ns
`default_nettype none

module packet_assembler #(
    parameter int unsigned CALL_COUNTER_SIZE = 2
) (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            req_i,
    input  emitter_pkg::trace_req_t         trace_req_i,
    input  emitter_pkg::addr_field_t        addr_field_i,
    input  logic [2**CALL_COUNTER_SIZE-1:0] irdepth_i,
    input  emitter_pkg::bmap_field_t        bmap_field_i,
    output logic                            latest_update_o,
    output logic                            ack_o,
    output logic                            branch_map_flush_o,
    output emitter_pkg::packet_t            packet_o
);

    import etrace_pkg::*;
    import emitter_pkg::*;

    localparam int unsigned IRDEPTH_LEN = 2**CALL_COUNTER_SIZE;

    hs_state_e      state_q;
    hs_state_e      state_d;
    logic           capture;
    logic           flush_q;
    packet_t        packet_q;

    payload_t       payload;
    payload_len_t   length;
    packet_type_e   ptype;
    logic [6:0]     used_bits;
    logic [6:0]     addr_bits;
    logic           update;
    logic           with_addr;
    logic           branch;
    cause_t         ecause;
    logic           interrupt;
    addr_t          tval;

    // request taken on the first edge with req high and ack low
    assign capture = (state_q == IDLE) && req_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (req_i) state_d = ACK;
            ACK: if (!req_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // trap fields from this cycle or last cycle
    assign ecause    = trace_req_i.lc_tc_sel ? trace_req_i.tc_cause : trace_req_i.lc_cause;
    assign interrupt = trace_req_i.lc_tc_sel ? trace_req_i.tc_interrupt
                                             : trace_req_i.lc_interrupt;
    assign tval      = trace_req_i.lc_tc_sel ? trace_req_i.tc_tval : trace_req_i.lc_tval;

    // set unless this is a taken branch
    assign branch    = ~(trace_req_i.tc_branch & trace_req_i.tc_branch_taken);
    assign addr_bits = {1'b0, addr_field_i.n_bytes, 3'b000};

    // fields go in from bit 0 upward, used_bits is the running offset
    always_comb begin
        payload   = '0;
        ptype     = F1;
        update    = 1'b0;
        with_addr = 1'b0;
        payload[1:0] = trace_req_i.format;
        used_bits    = 7'd2;
        case (trace_req_i.format)
            F_SYNC: begin
                payload[3:2] = trace_req_i.subformat;
                used_bits    = 7'd4;
                case (trace_req_i.subformat)
                    SF_START: begin
                        ptype  = F3SF0;
                        update = 1'b1;
                        payload |= payload_t'({addr_field_i.addr, trace_req_i.tc_priv, branch})
                                   << used_bits;
                        used_bits = used_bits + 7'(1 + PRIV_LEN) + addr_bits;
                    end
                    SF_TRAP: begin
                        ptype  = F3SF1;
                        update = 1'b1;
                        payload |= payload_t'({addr_field_i.addr, trace_req_i.thaddr, interrupt,
                                              ecause, trace_req_i.tc_priv, branch}) << used_bits;
                        used_bits = used_bits + 7'(3 + PRIV_LEN + CAUSE_LEN) + addr_bits;
                        // full tval after the kept address bytes
                        payload |= payload_t'(tval) << used_bits;
                        used_bits = used_bits + 7'(XLEN);
                    end
                    SF_CONTEXT: begin
                        ptype = F3SF2;
                        payload |= payload_t'(trace_req_i.tc_priv) << used_bits;
                        used_bits = used_bits + 7'(PRIV_LEN);
                    end
                    default: begin
                        ptype = F3SF3;
                        payload |= payload_t'({trace_req_i.ioptions, trace_req_i.qual_status,
                                              trace_req_i.encoder_mode, trace_req_i.tc_ienable})
                                   << used_bits;
                        used_bits = used_bits + 7'd7;
                    end
                endcase
            end
            F_ADDR_ONLY: begin
                ptype     = F2;
                update    = 1'b1;
                with_addr = 1'b1;
            end
            F_DIFF_DELTA: begin
                ptype  = F1;
                update = 1'b1;
                payload |= payload_t'(bmap_field_i.bits) << used_bits;
                used_bits = used_bits + 7'(BRANCH_COUNT_LEN) + 7'(bmap_field_i.map_len);
                // full map goes without an address
                with_addr = ~bmap_field_i.full;
            end
            default: begin
                // format 0 is not generated
                payload   = '0;
                used_bits = '0;
            end
        endcase
        // shared address tail of formats 1 and 2
        if (with_addr) begin
            payload |= payload_t'(addr_field_i.addr) << used_bits;
            used_bits = used_bits + addr_bits;
            payload |= payload_t'({irdepth_i, addr_field_i.irreport, addr_field_i.updiscon,
                                  addr_field_i.notify}) << used_bits;
            used_bits = used_bits + 7'(3 + IRDEPTH_LEN);
        end
    end

    // bytes rounded up
    assign length = payload_len_t'((used_bits + 7'd7) >> 3);

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= IDLE;
            flush_q  <= 1'b0;
            packet_q <= '0;
        end else begin
            state_q <= state_d;
            // flush only in the first ack cycle
            flush_q <= capture;
            if (capture) begin
                packet_q.ptype   <= ptype;
                packet_q.payload <= payload;
                packet_q.length  <= length;
            end
        end
    end

    assign latest_update_o    = capture & update;
    assign ack_o              = (state_q == ACK);
    assign branch_map_flush_o = flush_q;
    assign packet_o           = packet_q;

endmodule

`default_nettype wire

//--- verilog/trace_packet_emitter.sv
// top level of the trace packet emitter: address path and branch path
// feed the packet assembler, which owns the req/ack handshake
`timescale 1ns/1ns
`default_nettype none

module trace_packet_emitter #(
    // sets the irdepth field width
    parameter int unsigned CALL_COUNTER_SIZE = 2
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        req_i,
    input  emitter_pkg::trace_req_t     trace_req_i,
    output logic                        ack_o,
    output emitter_pkg::packet_t        packet_o,
    output logic                        branch_map_flush_o
);

    import emitter_pkg::*;

    addr_field_t                        addr_field;
    bmap_field_t                        bmap_field;
    logic [2**CALL_COUNTER_SIZE-1:0]    irdepth;
    // last-address load on the capture edge
    logic                               latest_update;

    addr_field_gen #(
        .CALL_COUNTER_SIZE (CALL_COUNTER_SIZE)
    ) addr_field_gen_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .trace_req_i     (trace_req_i),
        .latest_update_i (latest_update),
        .addr_field_o    (addr_field),
        .irdepth_o       (irdepth)
    );

    branch_map_field branch_map_field_i (
        .trace_req_i  (trace_req_i),
        .bmap_field_o (bmap_field)
    );

    packet_assembler #(
        .CALL_COUNTER_SIZE (CALL_COUNTER_SIZE)
    ) packet_assembler_i (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .req_i              (req_i),
        .trace_req_i        (trace_req_i),
        .addr_field_i       (addr_field),
        .irdepth_i          (irdepth),
        .bmap_field_i       (bmap_field),
        .latest_update_o    (latest_update),
        .ack_o              (ack_o),
        .branch_map_flush_o (branch_map_flush_o),
        .packet_o           (packet_o)
    );

endmodule

`default_nettype wire
